//--- hw/nand_params.svh
`ifndef NAND_PARAMS_SVH
`define NAND_PARAMS_SVH

// flash bus and page geometry
`define NAND_DQ_W        8
`define NAND_PAGE_BYTES  16
`define NAND_PAGE_AW     4
`define NAND_ROW_W       17
`define NAND_COL_W       12
`define NAND_COL_CYCLES  2
`define NAND_ROW_CYCLES  3

// strobe timing in clk cycles
`define NAND_T_WLWH      4
`define NAND_T_RLQV      4
`define NAND_T_WB        4   // confirm cmd to first look at rb_n

`define APB_AW           8
`define APB_DW           32

`endif

//--- hw/nand_pkg.sv
package nand_pkg;

	// software visible operation codes
	typedef enum logic [2:0] {
		op_reset        = 3'd0,
		op_read_status  = 3'd1,
		op_read_id      = 3'd2,
		op_read_page    = 3'd3,
		op_program_page = 3'd4,
		op_erase_block  = 3'd5
	} nand_op_e;

	// command bytes on the flash bus
	typedef enum logic [7:0] {
		oc_read1  = 8'h00,
		oc_prog2  = 8'h10,
		oc_read2  = 8'h30,
		oc_erase1 = 8'h60,
		oc_status = 8'h70,
		oc_prog1  = 8'h80,
		oc_id     = 8'h90,
		oc_erase2 = 8'hD0,
		oc_reset  = 8'hFF
	} nand_opcode_e;

	typedef enum logic [3:0] {
		s_idle, s_cmd1, s_addr, s_wdata, s_cmd2, s_wait, s_stat, s_rdata, s_done
	} seq_state_e;

	typedef enum logic [2:0] {
		ph_cmd, ph_addr, ph_wdata, ph_rdata, ph_wait_rdy
	} phy_op_e;

	typedef enum logic [2:0] {
		ps_idle, ps_setup, ps_pulse, ps_wait, ps_ack
	} phy_state_e;

endpackage

//--- hw/nand_cmd_if.sv
`timescale 1ns/1ps
`include "nand_params.svh"

// operation request from register block, results back from sequencer
interface nand_cmd_if;
	logic start;   // single cycle
	nand_pkg::nand_op_e op;
	logic [`NAND_ROW_W-1:0] row;
	logic [`NAND_COL_W-1:0] col;
	logic busy;
	logic done;    // single cycle, busy already low
	logic [`NAND_DQ_W-1:0] status;
	logic [3:0][`NAND_DQ_W-1:0] id;   // id[0] is the first byte read

	modport regs (output start, op, row, col, input busy, done, status, id);
	modport seq (input start, op, row, col, output busy, done, status, id);
endinterface

//--- hw/nand_phy_if.sv
`timescale 1ns/1ps
`include "nand_params.svh"

// one flash bus cycle per req/ack handshake
interface nand_phy_if;
	logic req;     // held until ack
	nand_pkg::phy_op_e kind;
	logic [`NAND_DQ_W-1:0] wdata;
	logic ack;
	logic [`NAND_DQ_W-1:0] rdata;   // valid with ack of a ph_rdata cycle

	modport seq (output req, kind, wdata, input ack, rdata);
	modport phy (input req, kind, wdata, output ack, rdata);
endinterface

//--- hw/nand_apb_regs.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_apb_regs (
	input  logic clk,
	input  logic rst,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [`APB_AW-1:0] paddr_i,
	input  logic [`APB_DW-1:0] pwdata_i,
	output logic [`APB_DW-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	nand_cmd_if.regs cmd,
	output logic [`NAND_PAGE_AW-1:0] buf_addr_o,
	output logic buf_we_o,
	output logic [`NAND_DQ_W-1:0] buf_wdata_o,
	input  logic [`NAND_DQ_W-1:0] buf_rdata_i
);
	localparam logic [`APB_AW-1:0] A_CMD = 'h00;
	localparam logic [`APB_AW-1:0] A_ROW = 'h04;
	localparam logic [`APB_AW-1:0] A_COL = 'h08;
	localparam logic [`APB_AW-1:0] A_STATUS = 'h0C;
	localparam logic [`APB_AW-1:0] A_ID = 'h10;
	localparam int BUF_LSB = `NAND_PAGE_AW + 2;   // word index above this
	localparam int OP_W = $bits(nand_pkg::nand_op_e);

	logic access;
	logic buf_hit;
	logic reg_hit;
	logic op_ok;
	logic cmd_busy;
	logic err;
	logic wr_ok;
	logic wr_cmd;
	logic start_q;
	logic done_sticky;
	nand_pkg::nand_op_e op_q;
	logic [`NAND_ROW_W-1:0] row_q;
	logic [`NAND_COL_W-1:0] col_q;

	assign access = psel_i & penable_i;
	assign buf_hit = (paddr_i[`APB_AW-1:BUF_LSB] == 1) && (paddr_i[1:0] == 2'b00);
	assign reg_hit = paddr_i inside {A_CMD, A_ROW, A_COL, A_STATUS, A_ID};
	assign cmd_busy = cmd.busy | start_q;   // start pending counts as busy
	assign op_ok = (pwdata_i[`APB_DW-1:OP_W] == '0) &&
		(pwdata_i[OP_W-1:0] <= nand_pkg::op_erase_block);
	assign err = !(buf_hit || reg_hit) ||
		(pwrite_i && paddr_i == A_CMD && (cmd_busy || !op_ok));
	assign wr_ok = access & pwrite_i & ~err;
	assign wr_cmd = wr_ok && paddr_i == A_CMD;

	assign pready_o = 1'b1;
	assign pslverr_o = access & err;

	// page buffer window
	assign buf_addr_o = paddr_i[BUF_LSB-1:2];
	assign buf_we_o = wr_ok & buf_hit;
	assign buf_wdata_o = pwdata_i[`NAND_DQ_W-1:0];

	assign cmd.start = start_q;
	assign cmd.op = op_q;
	assign cmd.row = row_q;
	assign cmd.col = col_q;

	always_comb begin
		prdata_o = '0;
		if (buf_hit)
			prdata_o[`NAND_DQ_W-1:0] = buf_rdata_i;
		else begin
			case (paddr_i)
				A_CMD: prdata_o[1:0] = {done_sticky | cmd.done, cmd_busy};   // done as busy drops
				A_ROW: prdata_o[`NAND_ROW_W-1:0] = row_q;
				A_COL: prdata_o[`NAND_COL_W-1:0] = col_q;
				A_STATUS: prdata_o[`NAND_DQ_W-1:0] = cmd.status;
				A_ID: prdata_o[4*`NAND_DQ_W-1:0] = cmd.id;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			start_q <= 1'b0;
			done_sticky <= 1'b0;
			op_q <= nand_pkg::op_reset;
			row_q <= '0;
			col_q <= '0;
		end else begin
			start_q <= wr_cmd;   // one cycle after the access phase
			if (wr_cmd)
				op_q <= nand_pkg::nand_op_e'(pwdata_i[OP_W-1:0]);
			if (wr_ok && paddr_i == A_ROW)
				row_q <= pwdata_i[`NAND_ROW_W-1:0];
			if (wr_ok && paddr_i == A_COL)
				col_q <= pwdata_i[`NAND_COL_W-1:0];
			if (start_q)
				done_sticky <= 1'b0;
			else if (cmd.done)
				done_sticky <= 1'b1;
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		cmd.start |-> !cmd.busy);

endmodule

//--- hw/nand_page_buf.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_page_buf (
	input  logic clk,
	input  logic [`NAND_PAGE_AW-1:0] apb_addr_i,
	input  logic apb_we_i,
	input  logic [`NAND_DQ_W-1:0] apb_wdata_i,
	output logic [`NAND_DQ_W-1:0] apb_rdata_o,
	input  logic [`NAND_PAGE_AW-1:0] seq_addr_i,
	input  logic seq_we_i,
	input  logic [`NAND_DQ_W-1:0] seq_wdata_i,
	output logic [`NAND_DQ_W-1:0] seq_rdata_o
);
	logic [`NAND_DQ_W-1:0] mem [`NAND_PAGE_BYTES];

	always_ff @(posedge clk) begin
		if (apb_we_i)
			mem[apb_addr_i] <= apb_wdata_i;
		// sequencer wins on a same-address collision
		if (seq_we_i)
			mem[seq_addr_i] <= seq_wdata_i;
	end

	assign apb_rdata_o = mem[apb_addr_i];   // async read
	assign seq_rdata_o = mem[seq_addr_i];

endmodule

//--- hw/nand_seq.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_seq (
	input  logic clk,
	input  logic rst,
	nand_cmd_if.seq cmd,
	nand_phy_if.seq phy,
	output logic ce_n_o,
	output logic [`NAND_PAGE_AW-1:0] buf_addr_o,
	output logic buf_we_o,
	output logic [`NAND_DQ_W-1:0] buf_wdata_o,
	input  logic [`NAND_DQ_W-1:0] buf_rdata_i
);
	localparam int AW = `NAND_PAGE_AW;
	localparam int COL_BITS = `NAND_COL_CYCLES * `NAND_DQ_W;
	localparam int ROW_BITS = `NAND_ROW_CYCLES * `NAND_DQ_W;

	nand_pkg::seq_state_e state;
	nand_pkg::nand_op_e op_q;
	logic [`NAND_ROW_W-1:0] row_q;
	logic [`NAND_COL_W-1:0] col_q;
	logic [AW-1:0] cnt;       // address and data bytes
	logic [AW-1:0] cnt_last;
	logic [AW-1:0] addr_idx;
	logic [ROW_BITS+COL_BITS-1:0] addr_vec;
	logic [`NAND_DQ_W-1:0] status_q;
	logic [3:0][`NAND_DQ_W-1:0] id_q;

	// column bytes first, each field low byte first
	assign addr_vec = {ROW_BITS'(row_q), COL_BITS'(col_q)};
	assign addr_idx = (op_q == nand_pkg::op_erase_block) ? cnt + AW'(`NAND_COL_CYCLES) : cnt;

	always_comb begin
		cnt_last = '0;
		case (state)
			nand_pkg::s_addr: begin
				if (op_q == nand_pkg::op_erase_block)
					cnt_last = AW'(`NAND_ROW_CYCLES - 1);
				else if (op_q != nand_pkg::op_read_id)
					cnt_last = AW'(`NAND_COL_CYCLES + `NAND_ROW_CYCLES - 1);
			end
			nand_pkg::s_wdata: cnt_last = AW'(`NAND_PAGE_BYTES - 1);
			nand_pkg::s_rdata: begin
				if (op_q == nand_pkg::op_read_page)
					cnt_last = AW'(`NAND_PAGE_BYTES - 1);
				else if (op_q == nand_pkg::op_read_id)
					cnt_last = AW'(3);
			end
			default: ;
		endcase
	end

	// bus cycle request follows the state directly
	always_comb begin
		phy.req = 1'b1;
		phy.kind = nand_pkg::ph_cmd;
		phy.wdata = '0;
		case (state)
			nand_pkg::s_cmd1: begin
				case (op_q)
					nand_pkg::op_reset: phy.wdata = nand_pkg::oc_reset;
					nand_pkg::op_read_status: phy.wdata = nand_pkg::oc_status;
					nand_pkg::op_read_id: phy.wdata = nand_pkg::oc_id;
					nand_pkg::op_program_page: phy.wdata = nand_pkg::oc_prog1;
					nand_pkg::op_erase_block: phy.wdata = nand_pkg::oc_erase1;
					default: phy.wdata = nand_pkg::oc_read1;
				endcase
			end
			nand_pkg::s_addr: begin
				phy.kind = nand_pkg::ph_addr;
				if (op_q != nand_pkg::op_read_id)   // id takes address 00
					phy.wdata = addr_vec[addr_idx*`NAND_DQ_W +: `NAND_DQ_W];
			end
			nand_pkg::s_wdata: begin
				phy.kind = nand_pkg::ph_wdata;
				phy.wdata = buf_rdata_i;
			end
			nand_pkg::s_cmd2: begin
				if (op_q == nand_pkg::op_read_page)
					phy.wdata = nand_pkg::oc_read2;
				else if (op_q == nand_pkg::op_program_page)
					phy.wdata = nand_pkg::oc_prog2;
				else
					phy.wdata = nand_pkg::oc_erase2;
			end
			nand_pkg::s_wait: phy.kind = nand_pkg::ph_wait_rdy;
			nand_pkg::s_stat: phy.wdata = nand_pkg::oc_status;   // status readback
			nand_pkg::s_rdata: phy.kind = nand_pkg::ph_rdata;
			default: phy.req = 1'b0;
		endcase
	end

	assign buf_addr_o = cnt;
	assign buf_we_o = (state == nand_pkg::s_rdata) && phy.ack && (op_q == nand_pkg::op_read_page);
	assign buf_wdata_o = phy.rdata;

	assign cmd.busy = (state != nand_pkg::s_idle) && (state != nand_pkg::s_done);
	assign cmd.done = (state == nand_pkg::s_done);
	assign cmd.status = status_q;
	assign cmd.id = id_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= nand_pkg::s_idle;
			op_q <= nand_pkg::op_reset;
			cnt <= '0;
			ce_n_o <= 1'b1;
			status_q <= '0;
			id_q <= '0;
		end else begin
			case (state)
				nand_pkg::s_idle: if (cmd.start) begin
					op_q <= cmd.op;
					cnt <= '0;
					ce_n_o <= 1'b0;
					state <= nand_pkg::s_cmd1;
				end
				nand_pkg::s_cmd1: if (phy.ack) begin
					if (op_q == nand_pkg::op_reset)
						state <= nand_pkg::s_wait;
					else if (op_q == nand_pkg::op_read_status)
						state <= nand_pkg::s_rdata;
					else
						state <= nand_pkg::s_addr;
				end
				nand_pkg::s_addr: if (phy.ack) begin
					cnt <= (cnt == cnt_last) ? '0 : cnt + 1'b1;
					if (cnt == cnt_last) begin
						if (op_q == nand_pkg::op_read_id)
							state <= nand_pkg::s_rdata;
						else if (op_q == nand_pkg::op_program_page)
							state <= nand_pkg::s_wdata;
						else
							state <= nand_pkg::s_cmd2;
					end
				end
				nand_pkg::s_wdata: if (phy.ack) begin
					cnt <= (cnt == cnt_last) ? '0 : cnt + 1'b1;
					if (cnt == cnt_last)
						state <= nand_pkg::s_cmd2;
				end
				nand_pkg::s_cmd2: if (phy.ack)
					state <= nand_pkg::s_wait;
				nand_pkg::s_wait: if (phy.ack) begin
					if (op_q == nand_pkg::op_read_page)
						state <= nand_pkg::s_rdata;
					else if (op_q == nand_pkg::op_reset)
						state <= nand_pkg::s_done;
					else
						state <= nand_pkg::s_stat;   // program and erase
				end
				nand_pkg::s_stat: if (phy.ack)
					state <= nand_pkg::s_rdata;
				nand_pkg::s_rdata: if (phy.ack) begin
					if (op_q == nand_pkg::op_read_id)
						id_q[cnt[1:0]] <= phy.rdata;
					else if (op_q != nand_pkg::op_read_page)
						status_q <= phy.rdata;
					cnt <= (cnt == cnt_last) ? '0 : cnt + 1'b1;
					if (cnt == cnt_last)
						state <= nand_pkg::s_done;
				end
				nand_pkg::s_done: begin
					ce_n_o <= 1'b1;
					state <= nand_pkg::s_idle;
				end
				default: state <= nand_pkg::s_idle;
			endcase
		end
	end

	// address fields captured with the request
	always_ff @(posedge clk) begin
		if (state == nand_pkg::s_idle && cmd.start) begin
			row_q <= cmd.row;
			col_q <= cmd.col;
		end
	end

	a_req_held: assert property (@(posedge clk) disable iff (rst)
		phy.req && !phy.ack |=> phy.req && $stable(phy.kind) && $stable(phy.wdata));

endmodule

//--- hw/nand_phy.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_phy (
	input  logic clk,
	input  logic rst,
	nand_phy_if.phy phy,
	output logic cle_o,
	output logic ale_o,
	output logic we_n_o,
	output logic re_n_o,
	output logic [`NAND_DQ_W-1:0] dq_o,
	output logic dq_oe_o,
	input  logic [`NAND_DQ_W-1:0] dq_i,
	input  logic rb_n_i
);
	localparam int CNT_W = 4;

	nand_pkg::phy_state_e state;
	logic [CNT_W-1:0] cnt;
	logic is_read;
	logic [`NAND_DQ_W-1:0] rdata_q;

	assign is_read = (phy.kind == nand_pkg::ph_rdata);
	assign phy.ack = (state == nand_pkg::ps_ack);
	assign phy.rdata = rdata_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= nand_pkg::ps_idle;
			cnt <= '0;
			cle_o <= 1'b0;
			ale_o <= 1'b0;
			we_n_o <= 1'b1;
			re_n_o <= 1'b1;
			dq_oe_o <= 1'b0;
		end else begin
			case (state)
				nand_pkg::ps_idle: if (phy.req) begin
					if (phy.kind == nand_pkg::ph_wait_rdy) begin
						cnt <= CNT_W'(`NAND_T_WB - 1);
						state <= nand_pkg::ps_wait;
					end else begin
						// latches and bus direction settle one cycle before the strobe
						cle_o <= (phy.kind == nand_pkg::ph_cmd);
						ale_o <= (phy.kind == nand_pkg::ph_addr);
						dq_oe_o <= !is_read;
						state <= nand_pkg::ps_setup;
					end
				end
				nand_pkg::ps_setup: begin
					if (is_read) begin
						re_n_o <= 1'b0;
						cnt <= CNT_W'(`NAND_T_RLQV - 1);
					end else begin
						we_n_o <= 1'b0;
						cnt <= CNT_W'(`NAND_T_WLWH - 1);
					end
					state <= nand_pkg::ps_pulse;
				end
				nand_pkg::ps_pulse: begin
					if (cnt != 0)
						cnt <= cnt - 1'b1;
					else begin
						we_n_o <= 1'b1;
						re_n_o <= 1'b1;
						state <= nand_pkg::ps_ack;
					end
				end
				nand_pkg::ps_wait: begin
					if (cnt != 0)
						cnt <= cnt - 1'b1;
					else if (rb_n_i)   // device ready again
						state <= nand_pkg::ps_ack;
				end
				nand_pkg::ps_ack: begin
					cle_o <= 1'b0;   // data hold through the ack cycle
					ale_o <= 1'b0;
					dq_oe_o <= 1'b0;
					state <= nand_pkg::ps_idle;
				end
				default: state <= nand_pkg::ps_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == nand_pkg::ps_idle && phy.req)
			dq_o <= phy.wdata;
		if (state == nand_pkg::ps_pulse && cnt == 0 && !re_n_o)
			rdata_q <= dq_i;   // sample at end of re_n low
	end

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(!we_n_o && !re_n_o));
	a_bus_dir: assert property (@(posedge clk) disable iff (rst)
		!(dq_oe_o && !re_n_o));

endmodule

//--- hw/nand_ctrl_top.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module nand_ctrl_top (
	input  logic clk,
	input  logic rst,
	input  logic psel_i,
	input  logic penable_i,
	input  logic pwrite_i,
	input  logic [`APB_AW-1:0] paddr_i,
	input  logic [`APB_DW-1:0] pwdata_i,
	output logic [`APB_DW-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output logic ce_n_o,
	output logic cle_o,
	output logic ale_o,
	output logic we_n_o,
	output logic re_n_o,
	output logic [`NAND_DQ_W-1:0] dq_o,
	output logic dq_oe_o,
	input  logic rb_n_i,
	input  logic [`NAND_DQ_W-1:0] dq_i
);
	nand_cmd_if cmd_if0 ();
	nand_phy_if phy_if0 ();

	logic [`NAND_PAGE_AW-1:0] apb_buf_addr;
	logic apb_buf_we;
	logic [`NAND_DQ_W-1:0] apb_buf_wdata;
	logic [`NAND_DQ_W-1:0] apb_buf_rdata;
	logic [`NAND_PAGE_AW-1:0] seq_buf_addr;
	logic seq_buf_we;
	logic [`NAND_DQ_W-1:0] seq_buf_wdata;
	logic [`NAND_DQ_W-1:0] seq_buf_rdata;

	nand_apb_regs regs0 (
		.clk(clk),
		.rst(rst),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.cmd(cmd_if0.regs),
		.buf_addr_o(apb_buf_addr),
		.buf_we_o(apb_buf_we),
		.buf_wdata_o(apb_buf_wdata),
		.buf_rdata_i(apb_buf_rdata)
	);

	nand_page_buf buf0 (
		.clk(clk),
		.apb_addr_i(apb_buf_addr),
		.apb_we_i(apb_buf_we),
		.apb_wdata_i(apb_buf_wdata),
		.apb_rdata_o(apb_buf_rdata),
		.seq_addr_i(seq_buf_addr),
		.seq_we_i(seq_buf_we),
		.seq_wdata_i(seq_buf_wdata),
		.seq_rdata_o(seq_buf_rdata)
	);

	nand_seq seq0 (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_if0.seq),
		.phy(phy_if0.seq),
		.ce_n_o(ce_n_o),
		.buf_addr_o(seq_buf_addr),
		.buf_we_o(seq_buf_we),
		.buf_wdata_o(seq_buf_wdata),
		.buf_rdata_i(seq_buf_rdata)
	);

	nand_phy phy0 (
		.clk(clk),
		.rst(rst),
		.phy(phy_if0.phy),
		.cle_o(cle_o),
		.ale_o(ale_o),
		.we_n_o(we_n_o),
		.re_n_o(re_n_o),
		.dq_o(dq_o),
		.dq_oe_o(dq_oe_o),
		.dq_i(dq_i),
		.rb_n_i(rb_n_i)
	);

endmodule

//--- dv/nand_flash_model.sv
`timescale 1ns/1ps
`include "nand_params.svh"

// behavioral NAND device, 64 pages of 16 bytes, 4 pages per block
module nand_flash_model (
	input  logic clk,
	input  logic rst,
	input  logic ce_n_i,
	input  logic cle_i,
	input  logic ale_i,
	input  logic we_n_i,
	input  logic re_n_i,
	input  logic [`NAND_DQ_W-1:0] dq_i,
	output logic [`NAND_DQ_W-1:0] dq_o,
	output logic rb_n_o
);
	localparam int ROWS = 64;
	localparam logic [7:0] STATUS_OK = 8'hE0;
	localparam logic [31:0] ID_BYTES = 32'h9590DA2C;   // 2C comes out first
	localparam logic [4:0] BUSY_CYCLES = 5'd12;

	typedef enum logic [1:0] {m_status, m_id, m_page} rd_mode_e;

	logic [7:0] mem [ROWS*16];
	logic [7:0] addr_b [5];
	logic [7:0] prog_buf [16];
	logic [2:0] addr_cnt;
	logic [3:0] wr_ptr;
	logic [3:0] rd_ptr;
	logic [5:0] rd_row;
	logic [3:0] rd_col;
	rd_mode_e mode;
	logic [4:0] busy_cnt;
	logic we_q;
	logic re_q;
	logic we_rise;
	logic re_rise;
	logic [7:0] rd_byte;

	function automatic logic [9:0] byte_idx(input logic [7:0] row_b, input logic [7:0] col_b,
			input int j);
		return {row_b[5:0], 4'(col_b[3:0] + 4'(j))};   // column wraps inside the page
	endfunction

	assign we_rise = we_n_i && !we_q && !ce_n_i;
	assign re_rise = re_n_i && !re_q && !ce_n_i;
	assign rb_n_o = (busy_cnt == 0);
	assign dq_o = (!ce_n_i && !re_n_i) ? rd_byte : 8'h00;

	always_comb begin
		case (mode)
			m_id: rd_byte = ID_BYTES[rd_ptr[1:0]*8 +: 8];
			m_page: rd_byte = mem[{rd_row, 4'(rd_col + rd_ptr)}];
			default: rd_byte = STATUS_OK;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			// power-up contents, not erased
			for (int i = 0; i < ROWS*16; i++)
				mem[i] <= 8'(i) ^ 8'(i >> 5) ^ 8'h5A;
			for (int i = 0; i < 5; i++)
				addr_b[i] <= 8'h00;
			addr_cnt <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			rd_row <= '0;
			rd_col <= '0;
			mode <= m_status;
			busy_cnt <= '0;
			we_q <= 1'b1;
			re_q <= 1'b1;
		end else begin
			we_q <= we_n_i;
			re_q <= re_n_i;
			if (busy_cnt != 0)
				busy_cnt <= busy_cnt - 1'b1;
			if (re_rise)
				rd_ptr <= rd_ptr + 1'b1;   // next byte on each re_n rise
			if (we_rise && cle_i) begin
				addr_cnt <= '0;
				wr_ptr <= '0;
				rd_ptr <= '0;
				case (dq_i)
					8'h70: mode <= m_status;
					8'h90: mode <= m_id;
					8'h80: begin
						for (int j = 0; j < 16; j++)
							prog_buf[j] <= 8'hFF;
					end
					8'h30: begin
						mode <= m_page;
						rd_row <= addr_b[2][5:0];
						rd_col <= addr_b[0][3:0];
						busy_cnt <= BUSY_CYCLES;
					end
					8'h10: begin
						for (int j = 0; j < 16; j++)
							mem[byte_idx(addr_b[2], addr_b[0], j)] <=
								mem[byte_idx(addr_b[2], addr_b[0], j)] & prog_buf[j];
						busy_cnt <= BUSY_CYCLES;
					end
					8'hD0: begin
						for (int j = 0; j < 64; j++)
							mem[{addr_b[0][5:2], 6'(j)}] <= 8'hFF;   // whole block
						busy_cnt <= BUSY_CYCLES;
					end
					8'hFF: begin
						mode <= m_status;
						busy_cnt <= BUSY_CYCLES;
					end
					default: ;
				endcase
			end
			if (we_rise && ale_i) begin
				if (addr_cnt < 3'd5)
					addr_b[addr_cnt] <= dq_i;
				addr_cnt <= addr_cnt + 1'b1;
			end
			if (we_rise && !cle_i && !ale_i) begin
				prog_buf[wr_ptr] <= dq_i;
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

endmodule

//--- dv/tb_nand_ctrl.sv
`timescale 1ns/1ps
`include "nand_params.svh"

module tb_nand_ctrl;
	localparam int HALF = 20;
	localparam int SETTLE = 10;   // sample point after the falling edge
	localparam int POLL_LIMIT = 300;
	localparam logic [7:0] A_CMD = 8'h00;
	localparam logic [7:0] A_ROW = 8'h04;
	localparam logic [7:0] A_COL = 8'h08;
	localparam logic [7:0] A_STATUS = 8'h0C;
	localparam logic [7:0] A_ID = 8'h10;
	localparam logic [7:0] A_HOLE = 8'h14;   // unmapped
	localparam logic [7:0] A_BUF = 8'h40;
	localparam logic [31:0] ID_EXP = 32'h9590DA2C;
	localparam logic [31:0] STATUS_EXP = 32'h000000E0;
	localparam int N_STEPS = 10;

	typedef struct packed {
		logic [2:0] code;
		logic [16:0] row;
		logic [11:0] col;
		logic [31:0] seed;   // page data source, 0 means erased
		logic exp_err;
		logic poke;          // extra accesses while the operation runs
	} step_t;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_AW-1:0] paddr;
	logic [`APB_DW-1:0] pwdata;
	logic [`APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;
	logic ce_n;
	logic cle;
	logic ale;
	logic we_n;
	logic re_n;
	logic dq_oe;
	logic rb_n;
	logic [`NAND_DQ_W-1:0] dq_out;
	logic [`NAND_DQ_W-1:0] dq_in;
	int errors = 0;
	int timeouts = 0;
	logic [7:0] page_exp [`NAND_PAGE_BYTES];

	step_t steps [N_STEPS] = '{
		'{nand_pkg::op_reset, 17'd0, 12'd0, 32'h0, 1'b0, 1'b0},
		'{nand_pkg::op_read_id, 17'd0, 12'd0, 32'h0, 1'b0, 1'b0},
		'{nand_pkg::op_read_status, 17'd0, 12'd0, 32'h0, 1'b0, 1'b0},
		'{nand_pkg::op_erase_block, 17'd8, 12'd0, 32'h0, 1'b0, 1'b0},
		'{nand_pkg::op_read_page, 17'd8, 12'd0, 32'h0, 1'b0, 1'b0},
		'{nand_pkg::op_program_page, 17'd8, 12'd0, 32'h749f, 1'b0, 1'b0},
		'{nand_pkg::op_read_page, 17'd8, 12'd0, 32'h749f, 1'b0, 1'b0},
		'{3'd6, 17'd0, 12'd0, 32'h0, 1'b1, 1'b0},
		'{3'd7, 17'd0, 12'd0, 32'h0, 1'b1, 1'b0},
		'{nand_pkg::op_read_page, 17'd8, 12'd0, 32'h749f, 1'b0, 1'b1}
	};

	nand_ctrl_top dut0 (
		.clk(clk),
		.rst(rst),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr),
		.ce_n_o(ce_n),
		.cle_o(cle),
		.ale_o(ale),
		.we_n_o(we_n),
		.re_n_o(re_n),
		.dq_o(dq_out),
		.dq_oe_o(dq_oe),
		.rb_n_i(rb_n),
		.dq_i(dq_in)
	);

	nand_flash_model flash0 (
		.clk(clk),
		.rst(rst),
		.ce_n_i(ce_n),
		.cle_i(cle),
		.ale_i(ale),
		.we_n_i(we_n),
		.re_n_i(re_n),
		.dq_i(dq_out),
		.dq_o(dq_in),
		.rb_n_o(rb_n)
	);

	initial begin
		clk = 1'b0;
		forever #HALF clk = ~clk;
	end

	// galois form, taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic make_page(input logic [31:0] seed);
		logic [31:0] s;
		logic [7:0] b;
		s = seed;
		for (int j = 0; j < `NAND_PAGE_BYTES; j++) begin
			for (int k = 0; k < 8; k++) begin
				b[k] = s[0];
				s = lfsr_next(s);
			end
			if (seed == 0)
				page_exp[j] = 8'hFF;
			else
				page_exp[j] = b;
		end
	endtask

	task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [`APB_DW-1:0] data,
			output logic err);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		#SETTLE;
		err = pslverr;
		check_eq("pready on write", 32'(pready), 32'd1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [`APB_DW-1:0] data,
			output logic err);
		@(negedge clk);
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		#SETTLE;
		data = prdata;
		err = pslverr;
		check_eq("pready on read", 32'(pready), 32'd1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_idle(output logic ok);
		logic [31:0] d;
		logic err;
		int polls;
		ok = 1'b0;
		polls = 0;
		while (!ok && polls < POLL_LIMIT) begin
			apb_read(A_CMD, d, err);
			ok = !d[0];
			polls++;
		end
		if (!ok) begin
			timeouts++;
			$display("operation did not finish after %0d polls at %0t", polls, $time);
		end else
			check_eq("done bit", 32'(d[1]), 32'd1);
	endtask

	task automatic check_result(input step_t e);
		logic [31:0] d;
		logic err;
		case (e.code)
			nand_pkg::op_reset: ;
			nand_pkg::op_read_id: begin
				apb_read(A_ID, d, err);
				check_eq("ID register", d, ID_EXP);
			end
			nand_pkg::op_read_page: begin
				make_page(e.seed);
				for (int j = 0; j < `NAND_PAGE_BYTES; j++) begin
					apb_read(8'(A_BUF + 4 * j), d, err);
					check_eq($sformatf("page byte %0d", j), d, 32'(page_exp[j]));
				end
			end
			default: begin   // status, program and erase end with a status read
				apb_read(A_STATUS, d, err);
				check_eq("STATUS register", d, STATUS_EXP);
			end
		endcase
	endtask

	task automatic run_step(input step_t e);
		logic err;
		logic ok;
		logic [31:0] d;
		if (e.code == nand_pkg::op_program_page) begin
			make_page(e.seed);
			for (int j = 0; j < `NAND_PAGE_BYTES; j++)
				apb_write(8'(A_BUF + 4 * j), 32'(page_exp[j]), err);
		end else if (e.code == nand_pkg::op_read_page) begin
			for (int j = 0; j < `NAND_PAGE_BYTES; j++)
				apb_write(8'(A_BUF + 4 * j), 32'd0, err);   // stale data must not survive
		end
		apb_write(A_ROW, 32'(e.row), err);
		apb_write(A_COL, 32'(e.col), err);
		apb_write(A_CMD, 32'(e.code), err);
		check_eq("pslverr on CMD write", 32'(err), 32'(e.exp_err));
		if (e.exp_err) begin
			apb_read(A_CMD, d, err);
			check_eq("busy after rejected CMD", 32'(d[0]), 32'd0);
		end else begin
			if (e.poke) begin
				apb_write(A_CMD, 32'(nand_pkg::op_read_id), err);
				check_eq("pslverr on CMD while busy", 32'(err), 32'd1);
				apb_read(A_HOLE, d, err);
				check_eq("pslverr on unmapped read", 32'(err), 32'd1);
			end
			wait_idle(ok);
			if (ok)
				check_result(e);
		end
	endtask

	initial begin
		logic [31:0] d;
		logic err;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		#SETTLE;
		check_eq("ce_n we_n re_n", 32'({ce_n, we_n, re_n}), 32'b111);
		check_eq("cle ale dq_oe", 32'({cle, ale, dq_oe}), 32'b000);
		apb_read(A_CMD, d, err);
		check_eq("busy after reset", 32'(d[0]), 32'd0);
		for (int i = 0; i < N_STEPS; i++)
			run_step(steps[i]);
		$display("errors %0d timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- project.f
+incdir+hw
hw/nand_pkg.sv
hw/nand_cmd_if.sv
hw/nand_phy_if.sv
hw/nand_apb_regs.sv
hw/nand_page_buf.sv
hw/nand_seq.sv
hw/nand_phy.sv
hw/nand_ctrl_top.sv
dv/nand_flash_model.sv
dv/tb_nand_ctrl.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_nand_ctrl > build.log 2>&1 &&
./obj_dir/Vtb_nand_ctrl > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
